// File: logic/io_cnt_pkg.sv
/*
 * shared localparams for the operator performance monitor
 * port counts, widths, port numbering, report sequence, counter-type codes
 */
package io_cnt_pkg;

    // widths
    localparam int PAYLOAD_BITS    = 32;  // one counter value
    localparam int NUM_PORT_BITS   = 4;   // port number field
    localparam int CNT_TYPE_BITS   = 2;   // counter-type field
    localparam int REPORT_IDX_BITS = 6;   // index of a report within a run
    localparam int PKT_WORD_BITS   = 40;  // kind + port + type + last + payload

    // queue counts
    localparam int NUM_IN_PORTS  = 7;
    localparam int NUM_OUT_PORTS = 7;

    // port numbering on the overlay, input queues 2..8, output queues 9..15
    localparam int INPUT_PORT_MIN  = 2;
    localparam int OUTPUT_PORT_MIN = 9;

    // report sequence
    // read, empty and full per input queue
    localparam int IN_REPORTS     = 3 * NUM_IN_PORTS;
    // full and empty per output queue (write count would repeat the input read count)
    localparam int OUT_REPORTS    = 2 * NUM_OUT_PORTS;
    localparam int NUM_QUEUE_CNTS = IN_REPORTS + OUT_REPORTS;  // counters outside the serializer
    localparam int NUM_REPORTS    = NUM_QUEUE_CNTS + 1;        // plus the stall report

    // counter-type codes carried in each report
    localparam logic [CNT_TYPE_BITS-1:0] CNT_TYPE_STALL = 2'd0;
    localparam logic [CNT_TYPE_BITS-1:0] CNT_TYPE_READ  = 2'd1;
    localparam logic [CNT_TYPE_BITS-1:0] CNT_TYPE_EMPTY = 2'd2;
    localparam logic [CNT_TYPE_BITS-1:0] CNT_TYPE_FULL  = 2'd3;

    /*
     * packet word layout, msb first
     *   [39]    kind      0 data, 1 trailer
     *   [38:35] self_port
     *   [34:33] cnt_type
     *   [32]    last      final data word and trailer
     *   [31:0]  payload   counter value or xor of all values
     */

endpackage

// File: logic/queue_event_counters.sv
/*
 * saturating cycle counters for the operator's queue status bits
 * input queues: full, empty, read; output queues: full, empty
 */
`timescale 1ns/100ps

module queue_event_counters (
    input  logic clk_user,
    input  logic reset_user,
    input  logic is_done_mode_user,

    input  logic [io_cnt_pkg::NUM_IN_PORTS-1:0]  in_queue_full,
    input  logic [io_cnt_pkg::NUM_IN_PORTS-1:0]  in_queue_empty,
    input  logic [io_cnt_pkg::NUM_IN_PORTS-1:0]  in_queue_read,
    input  logic [io_cnt_pkg::NUM_OUT_PORTS-1:0] out_queue_full,
    input  logic [io_cnt_pkg::NUM_OUT_PORTS-1:0] out_queue_empty,

    output logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_IN_PORTS-1:0]  input_port_full_cnt,
    output logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_IN_PORTS-1:0]  input_port_empty_cnt,
    output logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_IN_PORTS-1:0]  input_port_read_cnt,
    output logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_OUT_PORTS-1:0] output_port_full_cnt,
    output logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_OUT_PORTS-1:0] output_port_empty_cnt
);
    import io_cnt_pkg::*;

    logic [NUM_QUEUE_CNTS-1:0]              status_bits;
    logic [PAYLOAD_BITS*NUM_QUEUE_CNTS-1:0] cnt_flat;
    logic                                   count_en;

    // all status bits side by side, in the same order as the
    // flattened counter vector below (input read group at the bottom)
    assign status_bits = {out_queue_empty,
                          out_queue_full,
                          in_queue_full,
                          in_queue_empty,
                          in_queue_read};

    // counts freeze once the operator enters done mode, so the
    // serializer sees stable values while it walks through them
    assign count_en = !is_done_mode_user;

    genvar i;
    generate
        for (i = 0; i < NUM_QUEUE_CNTS; i = i + 1) begin : g_cnt
            logic [PAYLOAD_BITS-1:0] cnt;

            always_ff @(posedge clk_user) begin
                if (reset_user) begin
                    cnt <= '0;
                end else if (status_bits[i] && count_en && (cnt != '1)) begin
                    cnt <= cnt + 1'b1;  // stick at all ones
                end
            end

            assign cnt_flat[i*PAYLOAD_BITS +: PAYLOAD_BITS] = cnt;
        end
    endgenerate

    // split the flat vector back into per-kind groups, queue 0 in the low bits
    assign input_port_read_cnt  = cnt_flat[0 +: PAYLOAD_BITS*NUM_IN_PORTS];
    assign input_port_empty_cnt =
        cnt_flat[PAYLOAD_BITS*NUM_IN_PORTS +: PAYLOAD_BITS*NUM_IN_PORTS];
    assign input_port_full_cnt  =
        cnt_flat[2*PAYLOAD_BITS*NUM_IN_PORTS +: PAYLOAD_BITS*NUM_IN_PORTS];

    assign output_port_full_cnt =
        cnt_flat[PAYLOAD_BITS*IN_REPORTS +: PAYLOAD_BITS*NUM_OUT_PORTS];
    assign output_port_empty_cnt =
        cnt_flat[PAYLOAD_BITS*(IN_REPORTS+NUM_OUT_PORTS) +: PAYLOAD_BITS*NUM_OUT_PORTS];

endmodule

// File: logic/send_io_queue_cnt.sv
/*
 * serializer for the queue counters and the operator stall counter
 * emits one tagged report per cycle once the operator is done
 */
`timescale 1ns/100ps

module send_io_queue_cnt (
    input  logic clk_user,
    input  logic reset_user,
    input  logic is_done_user,
    input  logic is_done_mode_user,

    input  logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_IN_PORTS-1:0]  input_port_full_cnt,
    input  logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_IN_PORTS-1:0]  input_port_empty_cnt,
    input  logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_IN_PORTS-1:0]  input_port_read_cnt,
    input  logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_OUT_PORTS-1:0] output_port_full_cnt,
    input  logic [io_cnt_pkg::PAYLOAD_BITS*io_cnt_pkg::NUM_OUT_PORTS-1:0] output_port_empty_cnt,
    input  logic input_port_cluster_stall_condition,
    input  logic output_port_cluster_stall_condition,

    output logic                                   busy,
    output logic                                   report_valid,
    output logic [io_cnt_pkg::PAYLOAD_BITS-1:0]    cnt_val,
    output logic [io_cnt_pkg::NUM_PORT_BITS-1:0]   self_port,
    output logic [io_cnt_pkg::CNT_TYPE_BITS-1:0]   cnt_type,
    output logic [io_cnt_pkg::REPORT_IDX_BITS-1:0] report_idx
);
    import io_cnt_pkg::*;

    logic [PAYLOAD_BITS*NUM_IN_PORTS-1:0]  in_tmp;   // input group shift register
    logic [PAYLOAD_BITS*NUM_OUT_PORTS-1:0] out_tmp;  // output group shift register

    logic [REPORT_IDX_BITS-1:0] in_remain;     // input reports still to send
    logic [REPORT_IDX_BITS-1:0] out_remain;    // output reports still to send
    logic                       stall_remain;  // stall report still to send
    logic                       finished;      // run done, ignore further done pulses

    logic [PAYLOAD_BITS-1:0]  stall_cnt;
    logic                     stall_condition;
    logic                     in_active;
    logic                     out_active;
    logic                     any_remain;
    logic                     start;
    logic                     step;
    logic [PAYLOAD_BITS-1:0]  sel_val;
    logic [NUM_PORT_BITS-1:0] sel_port;
    logic [CNT_TYPE_BITS-1:0] sel_type;

    // stall cycles of this operator, either cluster counts
    assign stall_condition = input_port_cluster_stall_condition ||
                             output_port_cluster_stall_condition;

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            stall_cnt <= '0;
        end else if (stall_condition && !is_done_mode_user && (stall_cnt != '1)) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    assign in_active  = (in_remain != '0);
    assign out_active = (out_remain != '0);
    assign any_remain = in_active || out_active || stall_remain;

    // done may be held for several cycles, only the first idle sample counts
    assign start = !busy && !finished && is_done_user;
    assign step  = start || (busy && any_remain);

    // pick the next report, groups drain in order input, output, stall
    always_comb begin
        sel_val  = stall_cnt;
        sel_port = '0;                  // stall report has no queue
        sel_type = CNT_TYPE_STALL;
        if (in_active) begin
            sel_val = in_tmp[PAYLOAD_BITS-1:0];
            if (in_remain > 2*NUM_IN_PORTS) begin
                sel_type = CNT_TYPE_READ;
                sel_port = NUM_PORT_BITS'(INPUT_PORT_MIN + IN_REPORTS - in_remain);
            end else if (in_remain > NUM_IN_PORTS) begin
                sel_type = CNT_TYPE_EMPTY;
                sel_port = NUM_PORT_BITS'(INPUT_PORT_MIN + 2*NUM_IN_PORTS - in_remain);
            end else begin
                sel_type = CNT_TYPE_FULL;
                sel_port = NUM_PORT_BITS'(INPUT_PORT_MIN + NUM_IN_PORTS - in_remain);
            end
        end else if (out_active) begin
            sel_val = out_tmp[PAYLOAD_BITS-1:0];
            if (out_remain > NUM_OUT_PORTS) begin
                sel_type = CNT_TYPE_FULL;
                sel_port = NUM_PORT_BITS'(OUTPUT_PORT_MIN + OUT_REPORTS - out_remain);
            end else begin
                sel_type = CNT_TYPE_EMPTY;
                sel_port = NUM_PORT_BITS'(OUTPUT_PORT_MIN + NUM_OUT_PORTS - out_remain);
            end
        end
    end

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            busy         <= 1'b0;
            report_valid <= 1'b0;
            finished     <= 1'b0;
            in_remain    <= REPORT_IDX_BITS'(IN_REPORTS);
            out_remain   <= REPORT_IDX_BITS'(OUT_REPORTS);
            stall_remain <= 1'b1;
            report_idx   <= '0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (busy && !any_remain) begin
                busy     <= 1'b0;
                finished <= 1'b1;  // no restart until reset
            end

            report_valid <= step;

            if (step) begin
                report_idx <= start ? '0 : report_idx + 1'b1;
                if (in_active) begin
                    in_remain <= in_remain - 1'b1;
                end else if (out_active) begin
                    out_remain <= out_remain - 1'b1;
                end else begin
                    stall_remain <= 1'b0;
                end
            end
        end
    end

    // report payload and shift registers
    always_ff @(posedge clk_user) begin
        if (step) begin
            cnt_val   <= sel_val;
            self_port <= sel_port;
            cnt_type  <= sel_type;
            if (in_active) begin
                if (in_remain == 2*NUM_IN_PORTS + 1) begin
                    in_tmp <= input_port_empty_cnt;    // read group done
                end else if (in_remain == NUM_IN_PORTS + 1) begin
                    in_tmp <= input_port_full_cnt;     // empty group done
                end else begin
                    in_tmp <= in_tmp >> PAYLOAD_BITS;
                end
            end else if (out_active) begin
                if (out_remain == NUM_OUT_PORTS + 1) begin
                    out_tmp <= output_port_empty_cnt;  // full group done
                end else begin
                    out_tmp <= out_tmp >> PAYLOAD_BITS;
                end
            end
        end else if (!busy) begin
            // idle, keep the first group of each side ready
            in_tmp  <= input_port_read_cnt;
            out_tmp <= output_port_full_cnt;
        end
    end

endmodule

// File: logic/cnt_report_packetizer.sv
/*
 * frames counter reports into 40-bit packet words
 * marks the final data word and appends an xor trailer
 */
`timescale 1ns/100ps

module cnt_report_packetizer (
    input  logic                                   clk_user,
    input  logic                                   reset_user,
    input  logic                                   report_valid,
    input  logic [io_cnt_pkg::PAYLOAD_BITS-1:0]    cnt_val,
    input  logic [io_cnt_pkg::NUM_PORT_BITS-1:0]   self_port,
    input  logic [io_cnt_pkg::CNT_TYPE_BITS-1:0]   cnt_type,
    input  logic [io_cnt_pkg::REPORT_IDX_BITS-1:0] report_idx,

    output logic                                   pkt_valid,
    output logic [io_cnt_pkg::PKT_WORD_BITS-1:0]   pkt_word
);
    import io_cnt_pkg::*;

    logic [PAYLOAD_BITS-1:0] xor_acc;          // running xor of this run's payloads
    logic [PAYLOAD_BITS-1:0] xor_base;
    logic                    is_final;
    logic                    trailer_pending;  // trailer goes out next cycle

    assign is_final = (report_idx == REPORT_IDX_BITS'(NUM_REPORTS - 1));

    // first report of a run starts a fresh checksum
    assign xor_base = (report_idx == '0) ? '0 : xor_acc;

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            pkt_valid       <= 1'b0;
            trailer_pending <= 1'b0;
        end else begin
            pkt_valid       <= report_valid || trailer_pending;
            trailer_pending <= report_valid && is_final;
        end
    end

    always_ff @(posedge clk_user) begin
        if (report_valid) begin
            pkt_word <= {1'b0, self_port, cnt_type, is_final, cnt_val};
            xor_acc  <= xor_base ^ cnt_val;
        end else if (trailer_pending) begin
            // kind 1, port 0, stall type, last set
            pkt_word <= {1'b1, NUM_PORT_BITS'(0), CNT_TYPE_STALL, 1'b1, xor_acc};
        end
    end

endmodule

// File: logic/operator_monitor_top.sv
/*
 * performance monitor top for one user operator
 * queue counters -> serializer -> packetizer
 */
`timescale 1ns/100ps

module operator_monitor_top (
    input  logic clk_user,
    input  logic reset_user,
    input  logic is_done_user,
    input  logic is_done_mode_user,

    input  logic [io_cnt_pkg::NUM_IN_PORTS-1:0]  in_queue_full,
    input  logic [io_cnt_pkg::NUM_IN_PORTS-1:0]  in_queue_empty,
    input  logic [io_cnt_pkg::NUM_IN_PORTS-1:0]  in_queue_read,
    input  logic [io_cnt_pkg::NUM_OUT_PORTS-1:0] out_queue_full,
    input  logic [io_cnt_pkg::NUM_OUT_PORTS-1:0] out_queue_empty,
    input  logic input_port_cluster_stall_condition,
    input  logic output_port_cluster_stall_condition,

    output logic                                 busy,
    output logic                                 pkt_valid,
    output logic [io_cnt_pkg::PKT_WORD_BITS-1:0] pkt_word
);
    import io_cnt_pkg::*;

    // counter groups, queue 0 in the low bits
    logic [PAYLOAD_BITS*NUM_IN_PORTS-1:0]  input_port_full_cnt;
    logic [PAYLOAD_BITS*NUM_IN_PORTS-1:0]  input_port_empty_cnt;
    logic [PAYLOAD_BITS*NUM_IN_PORTS-1:0]  input_port_read_cnt;
    logic [PAYLOAD_BITS*NUM_OUT_PORTS-1:0] output_port_full_cnt;
    logic [PAYLOAD_BITS*NUM_OUT_PORTS-1:0] output_port_empty_cnt;

    // report stream between serializer and packetizer
    logic                       report_valid;
    logic [PAYLOAD_BITS-1:0]    cnt_val;
    logic [NUM_PORT_BITS-1:0]   self_port;
    logic [CNT_TYPE_BITS-1:0]   cnt_type;
    logic [REPORT_IDX_BITS-1:0] report_idx;

    queue_event_counters u_queue_event_counters (
        .clk_user              (clk_user),
        .reset_user            (reset_user),
        .is_done_mode_user     (is_done_mode_user),
        .in_queue_full         (in_queue_full),
        .in_queue_empty        (in_queue_empty),
        .in_queue_read         (in_queue_read),
        .out_queue_full        (out_queue_full),
        .out_queue_empty       (out_queue_empty),
        .input_port_full_cnt   (input_port_full_cnt),
        .input_port_empty_cnt  (input_port_empty_cnt),
        .input_port_read_cnt   (input_port_read_cnt),
        .output_port_full_cnt  (output_port_full_cnt),
        .output_port_empty_cnt (output_port_empty_cnt)
    );

    send_io_queue_cnt u_send_io_queue_cnt (
        .clk_user                            (clk_user),
        .reset_user                          (reset_user),
        .is_done_user                        (is_done_user),
        .is_done_mode_user                   (is_done_mode_user),
        .input_port_full_cnt                 (input_port_full_cnt),
        .input_port_empty_cnt                (input_port_empty_cnt),
        .input_port_read_cnt                 (input_port_read_cnt),
        .output_port_full_cnt                (output_port_full_cnt),
        .output_port_empty_cnt               (output_port_empty_cnt),
        .input_port_cluster_stall_condition  (input_port_cluster_stall_condition),
        .output_port_cluster_stall_condition (output_port_cluster_stall_condition),
        .busy                                (busy),
        .report_valid                        (report_valid),
        .cnt_val                             (cnt_val),
        .self_port                           (self_port),
        .cnt_type                            (cnt_type),
        .report_idx                          (report_idx)
    );

    cnt_report_packetizer u_cnt_report_packetizer (
        .clk_user     (clk_user),
        .reset_user   (reset_user),
        .report_valid (report_valid),
        .cnt_val      (cnt_val),
        .self_port    (self_port),
        .cnt_type     (cnt_type),
        .report_idx   (report_idx),
        .pkt_valid    (pkt_valid),
        .pkt_word     (pkt_word)
    );

endmodule

// File: tb/operator_monitor_props.sv
/*
 * bound assertions on the monitor's report stream
 * reset state, packet burst length, trailer framing, busy flag
 */
`timescale 1ns/100ps

module operator_monitor_props (
    input logic                                 clk_user,
    input logic                                 reset_user,
    input logic                                 busy,
    input logic                                 report_valid,
    input logic                                 pkt_valid,
    input logic [io_cnt_pkg::PKT_WORD_BITS-1:0] pkt_word
);
    import io_cnt_pkg::*;

    int         assert_fail_cnt;  // read by the testbench at the end of the run
    logic [6:0] valid_run;        // consecutive cycles with pkt_valid high
    logic       is_trailer;

    assign is_trailer = pkt_valid && pkt_word[PKT_WORD_BITS-1];

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            valid_run <= '0;
        end else if (pkt_valid) begin
            valid_run <= valid_run + 1'b1;
        end else begin
            valid_run <= '0;
        end
    end

    a_reset_quiet: assert property (@(posedge clk_user)
        reset_user |=> !busy && !pkt_valid && !report_valid)
        else begin
            $error("busy, report_valid or pkt_valid high in the cycle after reset");
            assert_fail_cnt = assert_fail_cnt + 1;
        end

    // 36 data words and the trailer form one unbroken burst
    a_burst_len: assert property (@(posedge clk_user) disable iff (reset_user)
        (!pkt_valid && (valid_run != '0)) |-> (valid_run == 7'(NUM_REPORTS + 1)))
        else begin
            $error("pkt_valid burst did not last for the full report sequence");
            assert_fail_cnt = assert_fail_cnt + 1;
        end

    a_burst_max: assert property (@(posedge clk_user) disable iff (reset_user)
        valid_run <= 7'(NUM_REPORTS + 1))
        else begin
            $error("pkt_valid stayed high longer than one report sequence");
            assert_fail_cnt = assert_fail_cnt + 1;
        end

    a_trailer_after_last: assert property (@(posedge clk_user) disable iff (reset_user)
        is_trailer |-> $past(pkt_valid) && !$past(pkt_word[PKT_WORD_BITS-1])
                       && $past(pkt_word[PAYLOAD_BITS]))
        else begin
            $error("trailer word not preceded by a data word with last set");
            assert_fail_cnt = assert_fail_cnt + 1;
        end

    a_report_busy: assert property (@(posedge clk_user) disable iff (reset_user)
        report_valid |-> busy)
        else begin
            $error("report_valid high while the serializer is not busy");
            assert_fail_cnt = assert_fail_cnt + 1;
        end

endmodule

bind operator_monitor_top operator_monitor_props u_operator_monitor_props (
    .clk_user     (clk_user),
    .reset_user   (reset_user),
    .busy         (busy),
    .report_valid (report_valid),
    .pkt_valid    (pkt_valid),
    .pkt_word     (pkt_word)
);

// File: tb/operator_monitor_tb.sv
/*
 * testbench for the operator performance monitor
 * random queue stimulus, reference counter model, packet capture and checks
 */
`timescale 1ns/100ps

module operator_monitor_tb;
    import io_cnt_pkg::*;

    localparam int RANDOM_CYCLES   = 200;
    localparam int REPORT_CYCLES   = 40;  // done to trailer plus margin
    localparam int SETTLE_CYCLES   = 20;
    localparam int WATCHDOG_CYCLES = RANDOM_CYCLES + 2*REPORT_CYCLES + SETTLE_CYCLES;
    localparam int NUM_WORDS       = NUM_REPORTS + 1;

    logic clk_user;
    logic reset_user;
    logic is_done_user;
    logic is_done_mode_user;
    logic [NUM_IN_PORTS-1:0]  in_queue_full;
    logic [NUM_IN_PORTS-1:0]  in_queue_empty;
    logic [NUM_IN_PORTS-1:0]  in_queue_read;
    logic [NUM_OUT_PORTS-1:0] out_queue_full;
    logic [NUM_OUT_PORTS-1:0] out_queue_empty;
    logic input_port_cluster_stall_condition;
    logic output_port_cluster_stall_condition;
    logic                     busy;
    logic                     pkt_valid;
    logic [PKT_WORD_BITS-1:0] pkt_word;

    integer seed = 74;
    int     mismatch_cnt;
    int     other_err_cnt;
    int     cycle_cnt;
    int     done_cycle;  // edge at which done was first sampled, -1 before
    int     word_cnt;

    // reference counts, frozen while done mode is high
    logic [PAYLOAD_BITS-1:0] exp_in_read  [NUM_IN_PORTS];
    logic [PAYLOAD_BITS-1:0] exp_in_empty [NUM_IN_PORTS];
    logic [PAYLOAD_BITS-1:0] exp_in_full  [NUM_IN_PORTS];
    logic [PAYLOAD_BITS-1:0] exp_out_full [NUM_OUT_PORTS];
    logic [PAYLOAD_BITS-1:0] exp_out_empty[NUM_OUT_PORTS];
    logic [PAYLOAD_BITS-1:0] exp_stall;

    operator_monitor_top u_operator_monitor_top (
        .clk_user                            (clk_user),
        .reset_user                          (reset_user),
        .is_done_user                        (is_done_user),
        .is_done_mode_user                   (is_done_mode_user),
        .in_queue_full                       (in_queue_full),
        .in_queue_empty                      (in_queue_empty),
        .in_queue_read                       (in_queue_read),
        .out_queue_full                      (out_queue_full),
        .out_queue_empty                     (out_queue_empty),
        .input_port_cluster_stall_condition  (input_port_cluster_stall_condition),
        .output_port_cluster_stall_condition (output_port_cluster_stall_condition),
        .busy                                (busy),
        .pkt_valid                           (pkt_valid),
        .pkt_word                            (pkt_word)
    );

    initial begin
        clk_user = 1'b0;
        forever #50 clk_user = ~clk_user;
    end

    always @(posedge clk_user) begin
        if (reset_user) begin
            for (int q = 0; q < NUM_IN_PORTS; q++) begin
                exp_in_read[q]  <= '0;
                exp_in_empty[q] <= '0;
                exp_in_full[q]  <= '0;
            end
            for (int q = 0; q < NUM_OUT_PORTS; q++) begin
                exp_out_full[q]  <= '0;
                exp_out_empty[q] <= '0;
            end
            exp_stall <= '0;
        end else if (!is_done_mode_user) begin
            for (int q = 0; q < NUM_IN_PORTS; q++) begin
                if (in_queue_read[q])  exp_in_read[q]  <= exp_in_read[q] + 32'd1;
                if (in_queue_empty[q]) exp_in_empty[q] <= exp_in_empty[q] + 32'd1;
                if (in_queue_full[q])  exp_in_full[q]  <= exp_in_full[q] + 32'd1;
            end
            for (int q = 0; q < NUM_OUT_PORTS; q++) begin
                if (out_queue_full[q])  exp_out_full[q]  <= exp_out_full[q] + 32'd1;
                if (out_queue_empty[q]) exp_out_empty[q] <= exp_out_empty[q] + 32'd1;
            end
            if (input_port_cluster_stall_condition || output_port_cluster_stall_condition)
                exp_stall <= exp_stall + 32'd1;
        end
    end

    // counter value carried by report k
    function automatic logic [PAYLOAD_BITS-1:0] expected_payload(input int k);
        int grp;
        int q;
        logic [PAYLOAD_BITS-1:0] val;
        val = exp_stall;
        if (k < 3*NUM_IN_PORTS) begin
            grp = k / NUM_IN_PORTS;
            q   = k % NUM_IN_PORTS;
            val = (grp == 0) ? exp_in_read[q] : (grp == 1) ? exp_in_empty[q] : exp_in_full[q];
        end else if (k < 3*NUM_IN_PORTS + 2*NUM_OUT_PORTS) begin
            grp = (k - 3*NUM_IN_PORTS) / NUM_OUT_PORTS;
            q   = (k - 3*NUM_IN_PORTS) % NUM_OUT_PORTS;
            val = (grp == 0) ? exp_out_full[q] : exp_out_empty[q];
        end
        return val;
    endfunction

    // full packet word k, the trailer is word NUM_REPORTS
    function automatic logic [PKT_WORD_BITS-1:0] expected_word(input int k);
        logic [PAYLOAD_BITS-1:0]  xor_sum;
        logic [NUM_PORT_BITS-1:0] port;
        logic [CNT_TYPE_BITS-1:0] ctype;
        int j;
        if (k == NUM_REPORTS) begin
            xor_sum = '0;
            for (int i = 0; i < NUM_REPORTS; i++) xor_sum = xor_sum ^ expected_payload(i);
            return {1'b1, NUM_PORT_BITS'(0), CNT_TYPE_STALL, 1'b1, xor_sum};
        end
        port  = '0;
        ctype = CNT_TYPE_STALL;
        if (k < 3*NUM_IN_PORTS) begin
            port  = NUM_PORT_BITS'(INPUT_PORT_MIN + k % NUM_IN_PORTS);
            ctype = (k < NUM_IN_PORTS) ? CNT_TYPE_READ :
                    (k < 2*NUM_IN_PORTS) ? CNT_TYPE_EMPTY : CNT_TYPE_FULL;
        end else if (k < NUM_REPORTS - 1) begin
            j     = k - 3*NUM_IN_PORTS;
            port  = NUM_PORT_BITS'(OUTPUT_PORT_MIN + j % NUM_OUT_PORTS);
            ctype = (j < NUM_OUT_PORTS) ? CNT_TYPE_FULL : CNT_TYPE_EMPTY;
        end
        return {1'b0, port, ctype, (k == NUM_REPORTS - 1), expected_payload(k)};
    endfunction

    always @(posedge clk_user) begin
        logic [PKT_WORD_BITS-1:0] exp_word;
        if (reset_user) begin
            cycle_cnt  <= 0;
            done_cycle <= -1;
            word_cnt   <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (is_done_user && done_cycle < 0) done_cycle <= cycle_cnt;
            if (done_cycle < 0) begin
                assert (!busy && !pkt_valid) else begin
                    other_err_cnt++;
                    $display("busy or pkt_valid high before any done pulse");
                end
            end else if (pkt_valid) begin
                if (word_cnt >= NUM_WORDS) begin
                    other_err_cnt++;
                    $display("extra packet word after the trailer, word %0d", word_cnt);
                end else begin
                    exp_word = expected_word(word_cnt);
                    assert (pkt_word == exp_word) else begin
                        mismatch_cnt++;
                        $display("MISMATCH pkt_word[%0d]: expected %h, got %h",
                                 word_cnt, exp_word, pkt_word);
                    end
                    // word k is registered at t+1+k and sampled here at t+2+k
                    assert (cycle_cnt == done_cycle + 2 + word_cnt) else begin
                        other_err_cnt++;
                        $display("packet word %0d arrived %0d cycles after done, not %0d",
                                 word_cnt, cycle_cnt - done_cycle, word_cnt + 2);
                    end
                    assert (busy == (word_cnt < NUM_REPORTS - 1)) else begin
                        mismatch_cnt++;
                        $display("MISMATCH busy at word %0d: expected %h, got %h",
                                 word_cnt, (word_cnt < NUM_REPORTS - 1), busy);
                    end
                end
                word_cnt <= word_cnt + 1;
            end
        end
    end

    task automatic randomize_status();
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        in_queue_full   <= rnd_a[0 +: NUM_IN_PORTS];
        in_queue_empty  <= rnd_a[8 +: NUM_IN_PORTS];
        in_queue_read   <= rnd_a[16 +: NUM_IN_PORTS];
        out_queue_full  <= rnd_a[24 +: NUM_OUT_PORTS];
        out_queue_empty <= rnd_b[0 +: NUM_OUT_PORTS];
        input_port_cluster_stall_condition  <= rnd_b[8];
        output_port_cluster_stall_condition <= rnd_b[9];
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge clk_user);
            randomize_status();
        end
    endtask

    initial begin
        reset_user        = 1'b1;
        is_done_user      = 1'b0;
        is_done_mode_user = 1'b0;
        in_queue_full     = '0;
        in_queue_empty    = '0;
        in_queue_read     = '0;
        out_queue_full    = '0;
        out_queue_empty   = '0;
        input_port_cluster_stall_condition  = 1'b0;
        output_port_cluster_stall_condition = 1'b0;
        repeat (2) @(posedge clk_user);
        reset_user <= 1'b0;

        run_cycles(RANDOM_CYCLES);
        is_done_mode_user <= 1'b1;  // counts freeze, status bits keep toggling
        run_cycles(2);
        is_done_user <= 1'b1;       // two-cycle pulse, only the first sample starts a run
        run_cycles(2);
        is_done_user <= 1'b0;
        while (word_cnt < NUM_WORDS) run_cycles(1);

        run_cycles(3);
        is_done_user <= 1'b1;       // second pulse must not restart the serializer
        run_cycles(1);
        is_done_user <= 1'b0;
        run_cycles(SETTLE_CYCLES);

        assert (word_cnt == NUM_WORDS) else begin
            other_err_cnt++;
            $display("captured %0d packet words instead of %0d", word_cnt, NUM_WORDS);
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_cnt, other_err_cnt,
                 u_operator_monitor_top.u_operator_monitor_props.assert_fail_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0 &&
            u_operator_monitor_top.u_operator_monitor_props.assert_fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_user);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: operator_monitor_top.f
logic/io_cnt_pkg.sv
logic/queue_event_counters.sv
logic/send_io_queue_cnt.sv
logic/cnt_report_packetizer.sv
logic/operator_monitor_top.sv
tb/operator_monitor_props.sv
tb/operator_monitor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the operator monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module operator_monitor_tb \
    -f operator_monitor_top.f \
    -o operator_monitor_sim

sim_out="$(./obj_dir/operator_monitor_sim +verilator+error+limit+100)" || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi
